// ==== verilog/cdm_regs_pkg.sv ====
`default_nettype none

package cdm_regs_pkg;

  //**********************************************************************
  // Bus and register widths
  //**********************************************************************
  localparam int axi_addr_width  = 10;  // Byte address, 1 KB window
  localparam int axi_data_width  = 32;  // One register per beat
  localparam int reg_index_width = 8;   // Word index from addr[9:2]

  typedef logic [axi_data_width-1:0]  reg_word_t;   // One register word
  typedef logic [reg_index_width-1:0] reg_index_t;  // Word index

  //**********************************************************************
  // Register map, by word index
  //**********************************************************************
  typedef enum reg_index_t {
    // Message store / load block
    msg_ctrl_0        = 8'h00,  // RW
    msg_ctrl_1        = 8'h01,  // RW
    msgst_rsp_status  = 8'h02,  // RO
    msgld_rsp_status  = 8'h03,  // RO
    msgld_pass_cnt    = 8'h04,  // RO pass count from load engine
    msgld_fail_cnt    = 8'h05,  // RO fail count from load engine

    // Kicks off all engines
    global_start      = 8'h3F,  // RW

    // PSX host side
    psx_msgst_addr_0  = 8'h40,  // RW store address, low word
    psx_msgst_addr_1  = 8'h41,  // RW store address, high word
    psx_msgld_addr_0  = 8'h42,  // RW load address, low word
    psx_msgld_addr_1  = 8'h43,  // RW load address, high word
    psx_host_reqid    = 8'h44,  // RW
    psx_host_ctrl     = 8'h46,  // RW

    // Streaming to message
    st2m_ctrl         = 8'h80,  // RW bit 0 start, [31:1] message count
    st2m_rsp_status   = 8'h81,  // RO

    // Message to streaming
    m2st_ctrl         = 8'h93,  // RW bit 0 start, bit 1 counter mode
    m2st_rsp_status   = 8'h95,  // RO
    m2st_psx_pass_cnt = 8'h96,  // RO
    m2st_psx_fail_cnt = 8'h97,  // RO

    // Engine soft reset, active low bits
    soft_rst_n        = 8'h98   // RW
  } reg_index_e;

  //**********************************************************************
  // Fixed words
  //**********************************************************************

  // Returned on a read that hits no register
  localparam reg_word_t unmapped_read_word = 32'h0000_DEAD;

  // Only response this slave ever gives
  localparam logic [1:0] axi_resp_okay = 2'b00;

endpackage : cdm_regs_pkg

`default_nettype wire

// ==== verilog/reg_access_if.sv ====
`default_nettype none

// Register access path between the bus slave and the register bank
interface reg_access_if;

  // Write side, one strobe per accepted W beat
  logic                    wr_en;     // Single cycle, bank always takes it
  cdm_regs_pkg::reg_index_t wr_index;  // Word index latched from AW
  cdm_regs_pkg::reg_word_t  wr_data;   // Full word, no byte lanes

  // Read side
  cdm_regs_pkg::reg_index_t rd_index;  // Word index latched from AR
  cdm_regs_pkg::reg_word_t  rd_data;   // Comb from rd_index

  // Slave end
  modport bus (
    output wr_en,
    output wr_index,
    output wr_data,
    output rd_index,
    input  rd_data
  );

  // Register bank end
  modport bank (
    input  wr_en,
    input  wr_index,
    input  wr_data,
    input  rd_index,
    output rd_data
  );

endinterface : reg_access_if

`default_nettype wire

// ==== verilog/axil_slave_port.sv ====
`default_nettype none

module axil_slave_port (
  input  wire logic                                      axi_aclk,
  input  wire logic                                      axi_aresetn,

  // Write address channel
  input  wire logic [cdm_regs_pkg::axi_addr_width-1:0]   awaddr,
  input  wire logic                                      awvalid,
  output logic                                           awready,

  // Write data channel, strobes not used
  input  cdm_regs_pkg::reg_word_t                        wdata,
  input  wire logic                                      wvalid,
  output logic                                           wready,

  // Write response channel
  output logic [1:0]                                     bresp,
  output logic                                           bvalid,
  input  wire logic                                      bready,

  // Read address channel
  input  wire logic [cdm_regs_pkg::axi_addr_width-1:0]   araddr,
  input  wire logic                                      arvalid,
  output logic                                           arready,

  // Read data channel
  output cdm_regs_pkg::reg_word_t                        rdata,
  output logic [1:0]                                     rresp,
  output logic                                           rvalid,
  input  wire logic                                      rready,

  reg_access_if.bus                                      regs
);

  logic                     reset_released;    // First clock out of reset
  logic                     reset_released_r;  // Second clock, opens the channels
  logic                     wr_req;            // Write open, AW taken
  logic                     rd_req;            // Read open, AR taken
  cdm_regs_pkg::reg_index_t wr_index_q;        // Word index of open write
  cdm_regs_pkg::reg_index_t rd_index_q;        // Word index of open read
  logic                     w_xfer;            // W beat this edge

  //**********************************************************************
  // Ready equations
  //**********************************************************************

  // One transaction at a time; a waiting or pending read holds off AW
  assign awready = ~wr_req && ~rd_req && ~arvalid && reset_released_r;
  assign arready = ~wr_req && ~rd_req && reset_released_r;
  assign wready  = wr_req && ~bvalid;  // Open until the beat lands

  assign w_xfer  = wready && wvalid;

  assign bresp   = cdm_regs_pkg::axi_resp_okay;  // Always OKAY
  assign rresp   = cdm_regs_pkg::axi_resp_okay;

  // Bank side
  assign regs.wr_en    = w_xfer;
  assign regs.wr_index = wr_index_q;
  assign regs.wr_data  = wdata;      // Whole word, strobes ignored
  assign regs.rd_index = rd_index_q;

  //**********************************************************************
  // Reset release
  //**********************************************************************

  // Keeps AW/AR low for two clocks after reset goes away
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      reset_released   <= 1'b0;
      reset_released_r <= 1'b0;
    end else begin
      reset_released   <= 1'b1;
      reset_released_r <= reset_released;
    end
  end

  //**********************************************************************
  // Transaction flags
  //**********************************************************************
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      wr_req <= 1'b0;
      rd_req <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        wr_req <= 1'b1;
      end else if (bvalid && bready) begin
        wr_req <= 1'b0;                // Response taken, channel free
      end

      if (arvalid && arready) begin
        rd_req <= 1'b1;
      end else if (rvalid && rready) begin
        rd_req <= 1'b0;
      end
    end
  end

  // Word index only, byte offset bits [1:0] dropped
  always_ff @(posedge axi_aclk) begin
    if (awvalid && awready) begin
      wr_index_q <= awaddr[cdm_regs_pkg::axi_addr_width-1:2];
    end
    if (arvalid && arready) begin
      rd_index_q <= araddr[cdm_regs_pkg::axi_addr_width-1:2];
    end
  end

  //**********************************************************************
  // Read data and write response
  //**********************************************************************
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (rd_req) begin
      rvalid <= !(rvalid && rready);  // Drops on the R beat
      if (!rvalid) begin
        rdata <= regs.rd_data;        // Sampled once, held under back-pressure
      end
    end else begin
      rvalid <= 1'b0;
      rdata  <= '0;                   // Idle bus reads as zero
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      bvalid <= 1'b0;
    end else if (w_xfer) begin
      bvalid <= 1'b1;                 // Same edge as the register update
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

endmodule : axil_slave_port

`default_nettype wire

// ==== verilog/cdm_ctrl_reg_bank.sv ====
`default_nettype none

module cdm_ctrl_reg_bank (
  input  wire logic                 axi_aclk,
  input  wire logic                 axi_aresetn,

  // Status from the engines, read only
  input  cdm_regs_pkg::reg_word_t   msgst_rsp_status,
  input  cdm_regs_pkg::reg_word_t   msgld_rsp_status,
  input  cdm_regs_pkg::reg_word_t   msgld_pass_counter_stats,
  input  cdm_regs_pkg::reg_word_t   msgld_fail_counter_stats,
  input  cdm_regs_pkg::reg_word_t   st2m_rsp_status,   // bit 0 req done, bit 1 all sent
  input  cdm_regs_pkg::reg_word_t   m2st_rsp_status,   // bit 0 req done
  input  cdm_regs_pkg::reg_word_t   m2st_psx_pass_cnt,
  input  cdm_regs_pkg::reg_word_t   m2st_psx_fail_cnt,

  // Control words to the engines
  output cdm_regs_pkg::reg_word_t   global_start,
  output cdm_regs_pkg::reg_word_t   msg_ctrl_reg_0,
  output cdm_regs_pkg::reg_word_t   msg_ctrl_reg_1,
  output cdm_regs_pkg::reg_word_t   psx_msgst_host_addr_0,
  output cdm_regs_pkg::reg_word_t   psx_msgst_host_addr_1,
  output cdm_regs_pkg::reg_word_t   psx_msgld_host_addr_0,
  output cdm_regs_pkg::reg_word_t   psx_msgld_host_addr_1,
  output cdm_regs_pkg::reg_word_t   psx_host_reqid,
  output cdm_regs_pkg::reg_word_t   psx_host_ctrl_reg,
  output cdm_regs_pkg::reg_word_t   st2m_ctrl_reg,     // bit 0 start, [31:1] count
  output cdm_regs_pkg::reg_word_t   m2st_ctrl_reg,     // bit 0 start, [31:2] count
  output cdm_regs_pkg::reg_word_t   soft_rst_n,

  reg_access_if.bank                regs
);

  //**********************************************************************
  // Write decode
  //**********************************************************************

  // Status and unmapped indexes fall to default, the beat is dropped
  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      global_start          <= '0;
      msg_ctrl_reg_0        <= '0;
      msg_ctrl_reg_1        <= '0;
      psx_msgst_host_addr_0 <= '0;
      psx_msgst_host_addr_1 <= '0;
      psx_msgld_host_addr_0 <= '0;
      psx_msgld_host_addr_1 <= '0;
      psx_host_reqid        <= '0;
      psx_host_ctrl_reg     <= '0;
      st2m_ctrl_reg         <= '0;
      m2st_ctrl_reg         <= '0;
      soft_rst_n            <= '0;  // Engines held in reset until SW lets go
    end else if (regs.wr_en) begin
      case (regs.wr_index)
        // Message block
        cdm_regs_pkg::msg_ctrl_0:        msg_ctrl_reg_0        <= regs.wr_data;
        cdm_regs_pkg::msg_ctrl_1:        msg_ctrl_reg_1        <= regs.wr_data;
        cdm_regs_pkg::global_start:      global_start          <= regs.wr_data;

        // PSX host addresses, 64 bit each as two words
        cdm_regs_pkg::psx_msgst_addr_0:  psx_msgst_host_addr_0 <= regs.wr_data;
        cdm_regs_pkg::psx_msgst_addr_1:  psx_msgst_host_addr_1 <= regs.wr_data;
        cdm_regs_pkg::psx_msgld_addr_0:  psx_msgld_host_addr_0 <= regs.wr_data;
        cdm_regs_pkg::psx_msgld_addr_1:  psx_msgld_host_addr_1 <= regs.wr_data;
        cdm_regs_pkg::psx_host_reqid:    psx_host_reqid        <= regs.wr_data;
        cdm_regs_pkg::psx_host_ctrl:     psx_host_ctrl_reg     <= regs.wr_data;

        // Streaming engines
        cdm_regs_pkg::st2m_ctrl:         st2m_ctrl_reg         <= regs.wr_data;
        cdm_regs_pkg::m2st_ctrl:         m2st_ctrl_reg         <= regs.wr_data;
        cdm_regs_pkg::soft_rst_n:        soft_rst_n            <= regs.wr_data;
        default: ;
      endcase
    end
  end

  //**********************************************************************
  // Read mux
  //**********************************************************************

  // Comb from the latched index; the slave registers the result
  always_comb begin
    case (regs.rd_index)
      // Message block
      cdm_regs_pkg::msg_ctrl_0:        regs.rd_data = msg_ctrl_reg_0;
      cdm_regs_pkg::msg_ctrl_1:        regs.rd_data = msg_ctrl_reg_1;
      cdm_regs_pkg::msgst_rsp_status:  regs.rd_data = msgst_rsp_status;
      cdm_regs_pkg::msgld_rsp_status:  regs.rd_data = msgld_rsp_status;
      cdm_regs_pkg::msgld_pass_cnt:    regs.rd_data = msgld_pass_counter_stats;
      cdm_regs_pkg::msgld_fail_cnt:    regs.rd_data = msgld_fail_counter_stats;
      cdm_regs_pkg::global_start:      regs.rd_data = global_start;

      // PSX host
      cdm_regs_pkg::psx_msgst_addr_0:  regs.rd_data = psx_msgst_host_addr_0;
      cdm_regs_pkg::psx_msgst_addr_1:  regs.rd_data = psx_msgst_host_addr_1;
      cdm_regs_pkg::psx_msgld_addr_0:  regs.rd_data = psx_msgld_host_addr_0;
      cdm_regs_pkg::psx_msgld_addr_1:  regs.rd_data = psx_msgld_host_addr_1;
      cdm_regs_pkg::psx_host_reqid:    regs.rd_data = psx_host_reqid;
      cdm_regs_pkg::psx_host_ctrl:     regs.rd_data = psx_host_ctrl_reg;

      // ST2M
      cdm_regs_pkg::st2m_ctrl:         regs.rd_data = st2m_ctrl_reg;
      cdm_regs_pkg::st2m_rsp_status:   regs.rd_data = st2m_rsp_status;

      // M2ST, control read back at its own write index
      cdm_regs_pkg::m2st_ctrl:         regs.rd_data = m2st_ctrl_reg;
      cdm_regs_pkg::m2st_rsp_status:   regs.rd_data = m2st_rsp_status;
      cdm_regs_pkg::m2st_psx_pass_cnt: regs.rd_data = m2st_psx_pass_cnt;
      cdm_regs_pkg::m2st_psx_fail_cnt: regs.rd_data = m2st_psx_fail_cnt;
      cdm_regs_pkg::soft_rst_n:        regs.rd_data = soft_rst_n;

      // Marker so SW can spot a bad offset
      default:                         regs.rd_data = cdm_regs_pkg::unmapped_read_word;
    endcase
  end

endmodule : cdm_ctrl_reg_bank

`default_nettype wire

// ==== verilog/cdm_adapt_ctrl_regs.sv ====
`default_nettype none

module cdm_adapt_ctrl_regs (
  // Control words out
  output cdm_regs_pkg::reg_word_t                      global_start,
  output cdm_regs_pkg::reg_word_t                      msg_ctrl_reg_0,
  output cdm_regs_pkg::reg_word_t                      msg_ctrl_reg_1,
  output cdm_regs_pkg::reg_word_t                      psx_msgst_host_addr_0,
  output cdm_regs_pkg::reg_word_t                      psx_msgst_host_addr_1,
  output cdm_regs_pkg::reg_word_t                      psx_msgld_host_addr_0,
  output cdm_regs_pkg::reg_word_t                      psx_msgld_host_addr_1,
  output cdm_regs_pkg::reg_word_t                      psx_host_reqid,
  output cdm_regs_pkg::reg_word_t                      psx_host_ctrl_reg,
  output cdm_regs_pkg::reg_word_t                      st2m_ctrl_reg,
  output cdm_regs_pkg::reg_word_t                      m2st_ctrl_reg,
  output cdm_regs_pkg::reg_word_t                      soft_rst_n,

  // Status words in
  input  cdm_regs_pkg::reg_word_t                      msgst_rsp_status,
  input  cdm_regs_pkg::reg_word_t                      msgld_rsp_status,
  input  cdm_regs_pkg::reg_word_t                      msgld_pass_counter_stats,
  input  cdm_regs_pkg::reg_word_t                      msgld_fail_counter_stats,
  input  cdm_regs_pkg::reg_word_t                      st2m_rsp_status,
  input  cdm_regs_pkg::reg_word_t                      m2st_rsp_status,
  input  cdm_regs_pkg::reg_word_t                      m2st_psx_pass_cnt,
  input  cdm_regs_pkg::reg_word_t                      m2st_psx_fail_cnt,

  // AXI4-Lite slave
  input  wire logic                                    axi_aclk,
  input  wire logic                                    axi_aresetn,
  input  wire logic [cdm_regs_pkg::axi_addr_width-1:0] axi_awaddr,
  input  wire logic                                    axi_awvalid,
  output logic                                         axi_awready,
  input  cdm_regs_pkg::reg_word_t                      axi_wdata,
  input  wire logic                                    axi_wvalid,
  output logic                                         axi_wready,
  output logic [1:0]                                   axi_bresp,
  output logic                                         axi_bvalid,
  input  wire logic                                    axi_bready,
  input  wire logic [cdm_regs_pkg::axi_addr_width-1:0] axi_araddr,
  input  wire logic                                    axi_arvalid,
  output logic                                         axi_arready,
  output cdm_regs_pkg::reg_word_t                      axi_rdata,
  output logic [1:0]                                   axi_rresp,
  output logic                                         axi_rvalid,
  input  wire logic                                    axi_rready
);

  reg_access_if regs_if ();  // Slave to bank, write strobe and read index

  // Bus side, one open transaction at a time
  axil_slave_port axil_slave_port_i (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .awaddr      (axi_awaddr),  .awvalid (axi_awvalid), .awready (axi_awready),
    .wdata       (axi_wdata),   .wvalid  (axi_wvalid),  .wready  (axi_wready),
    .bresp       (axi_bresp),   .bvalid  (axi_bvalid),  .bready  (axi_bready),
    .araddr      (axi_araddr),  .arvalid (axi_arvalid), .arready (axi_arready),
    .rdata       (axi_rdata),   .rresp   (axi_rresp),   .rvalid  (axi_rvalid),
    .rready      (axi_rready),
    .regs        (regs_if.bus)
  );

  // Register side, all ports by name
  cdm_ctrl_reg_bank cdm_ctrl_reg_bank_i (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .*,
    .regs        (regs_if.bank)
  );

endmodule : cdm_adapt_ctrl_regs

`default_nettype wire

// ==== test/axil_bfm_tasks.svh ====
// AXI4-Lite master tasks for the register block testbench
// Inputs driven on the rising edge, outputs sampled on the falling edge

localparam int handshake_limit = 64;  // Clocks before a wait gives up

// Compares one word, the signal named in the error line
task automatic check_value(input string name, input cdm_regs_pkg::reg_word_t exp,
                           input cdm_regs_pkg::reg_word_t got);
  assert (got === exp) else begin
    $display("ERROR %s: expected %h, got %h", name, exp, got);
    errors++;
  end
endtask

// Current level of a handshake flag, by port name
function automatic logic flag_level(input string name);
  case (name)
    "axi_awready": return axi_awready;
    "axi_wready":  return axi_wready;
    "axi_bvalid":  return axi_bvalid;
    "axi_arready": return axi_arready;
    default:       return axi_rvalid;
  endcase
endfunction

// Polls on falling edges until the flag is high
task automatic wait_flag(input string name, output bit ok);
  int cycles;
  cycles = 0;
  @(negedge axi_aclk);
  while (!flag_level(name) && cycles < handshake_limit) begin
    cycles++;
    @(negedge axi_aclk);
  end
  ok = flag_level(name);
  if (!ok) begin
    $display("Timeout: %s stayed low for %0d clocks", name, handshake_limit);
    errors++;
  end
endtask

// One full write, B response held off for hold_b extra clocks
task automatic axil_write(input logic [cdm_regs_pkg::axi_addr_width-1:0] addr,
                          input cdm_regs_pkg::reg_word_t data, input int hold_b);
  bit ok;
  @(posedge axi_aclk);
  axi_awaddr  <= addr;
  axi_awvalid <= 1'b1;
  axi_wdata   <= data;
  axi_wvalid  <= 1'b1;                 // W offered together with AW
  wait_flag("axi_awready", ok);
  @(posedge axi_aclk);                 // AW beat
  axi_awvalid <= 1'b0;
  aw_beat_time = $realtime;
  if (ok) wait_flag("axi_wready", ok);
  if (ok) @(posedge axi_aclk);         // W beat, control word updates here
  axi_wvalid <= 1'b0;
  if (ok) wait_flag("axi_bvalid", ok);
  if (ok) begin
    check_value("axi_bresp", '0, 32'(axi_bresp));  // OKAY
    repeat (hold_b + 1) @(posedge axi_aclk);
    axi_bready <= 1'b1;
    @(posedge axi_aclk);               // B beat
    axi_bready <= 1'b0;
  end
endtask

// One full read, R beat held off for hold_r extra clocks
task automatic axil_read(input logic [cdm_regs_pkg::axi_addr_width-1:0] addr,
                         input int hold_r, output cdm_regs_pkg::reg_word_t data);
  bit ok;
  data = '0;
  @(posedge axi_aclk);
  axi_araddr  <= addr;
  axi_arvalid <= 1'b1;
  wait_flag("axi_arready", ok);
  @(posedge axi_aclk);                 // AR beat
  axi_arvalid <= 1'b0;
  if (ok) wait_flag("axi_rvalid", ok);
  if (ok) begin
    data = axi_rdata;                  // Mid-cycle sample
    check_value("axi_rresp", '0, 32'(axi_rresp));
    repeat (hold_r + 1) @(posedge axi_aclk);
    axi_rready <= 1'b1;
    @(posedge axi_aclk);               // R beat
    axi_rready <= 1'b0;
    r_beat_time = $realtime;
  end
endtask

// ==== test/tb_cdm_adapt_ctrl_regs.sv ====
`default_nettype none

module tb_cdm_adapt_ctrl_regs;
  timeunit 1ns;
  timeprecision 1ps;

  logic                                    axi_aclk = 1'b0;
  logic                                    axi_aresetn;
  logic [cdm_regs_pkg::axi_addr_width-1:0] axi_awaddr;
  logic                                    axi_awvalid;
  logic                                    axi_awready;
  cdm_regs_pkg::reg_word_t                 axi_wdata;
  logic                                    axi_wvalid;
  logic                                    axi_wready;
  logic [1:0]                              axi_bresp;
  logic                                    axi_bvalid;
  logic                                    axi_bready;
  logic [cdm_regs_pkg::axi_addr_width-1:0] axi_araddr;
  logic                                    axi_arvalid;
  logic                                    axi_arready;
  cdm_regs_pkg::reg_word_t                 axi_rdata;
  logic [1:0]                              axi_rresp;
  logic                                    axi_rvalid;
  logic                                    axi_rready;

  cdm_regs_pkg::reg_word_t ctrl_out [12];              // Control words from the DUT
  cdm_regs_pkg::reg_word_t status_in [8];              // Status words into the DUT
  cdm_regs_pkg::reg_word_t model [12] = '{default: '0};  // Expected control words
  string ctrl_name [12] = '{"global_start", "msg_ctrl_reg_0", "msg_ctrl_reg_1",
    "psx_msgst_host_addr_0", "psx_msgst_host_addr_1", "psx_msgld_host_addr_0",
    "psx_msgld_host_addr_1", "psx_host_reqid", "psx_host_ctrl_reg", "st2m_ctrl_reg",
    "m2st_ctrl_reg", "soft_rst_n"};
  cdm_regs_pkg::reg_index_t rw_idx [12] = '{cdm_regs_pkg::global_start,
    cdm_regs_pkg::msg_ctrl_0, cdm_regs_pkg::msg_ctrl_1, cdm_regs_pkg::psx_msgst_addr_0,
    cdm_regs_pkg::psx_msgst_addr_1, cdm_regs_pkg::psx_msgld_addr_0,
    cdm_regs_pkg::psx_msgld_addr_1, cdm_regs_pkg::psx_host_reqid,
    cdm_regs_pkg::psx_host_ctrl, cdm_regs_pkg::st2m_ctrl, cdm_regs_pkg::m2st_ctrl,
    cdm_regs_pkg::soft_rst_n};
  cdm_regs_pkg::reg_index_t st_idx [8] = '{cdm_regs_pkg::msgst_rsp_status,
    cdm_regs_pkg::msgld_rsp_status, cdm_regs_pkg::msgld_pass_cnt,
    cdm_regs_pkg::msgld_fail_cnt, cdm_regs_pkg::st2m_rsp_status,
    cdm_regs_pkg::m2st_rsp_status, cdm_regs_pkg::m2st_psx_pass_cnt,
    cdm_regs_pkg::m2st_psx_fail_cnt};
  cdm_regs_pkg::reg_index_t holes [4] = '{8'h06, 8'h45, 8'h99, 8'hFF};  // Unmapped

  int      seed;
  int      errors = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  realtime aw_beat_time;  // Last AW transfer
  realtime r_beat_time;   // Last R transfer

  cdm_adapt_ctrl_regs dut_i (
    .global_start             (ctrl_out[0]),
    .msg_ctrl_reg_0           (ctrl_out[1]),
    .msg_ctrl_reg_1           (ctrl_out[2]),
    .psx_msgst_host_addr_0    (ctrl_out[3]),
    .psx_msgst_host_addr_1    (ctrl_out[4]),
    .psx_msgld_host_addr_0    (ctrl_out[5]),
    .psx_msgld_host_addr_1    (ctrl_out[6]),
    .psx_host_reqid           (ctrl_out[7]),
    .psx_host_ctrl_reg        (ctrl_out[8]),
    .st2m_ctrl_reg            (ctrl_out[9]),
    .m2st_ctrl_reg            (ctrl_out[10]),
    .soft_rst_n               (ctrl_out[11]),
    .msgst_rsp_status         (status_in[0]),
    .msgld_rsp_status         (status_in[1]),
    .msgld_pass_counter_stats (status_in[2]),
    .msgld_fail_counter_stats (status_in[3]),
    .st2m_rsp_status          (status_in[4]),
    .m2st_rsp_status          (status_in[5]),
    .m2st_psx_pass_cnt        (status_in[6]),
    .m2st_psx_fail_cnt        (status_in[7]),
    .*                                          // AXI ports by matching name
  );

  always #20 axi_aclk = ~axi_aclk;  // 40 ns period

  //**********************************************************************
  // Handshake checks
  //**********************************************************************
  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
    else begin
      $display("ERROR axi_rvalid/axi_rdata not held under back-pressure, now %h/%h",
               axi_rvalid, axi_rdata);
      errors++;
    end

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      axi_bvalid && !axi_bready |=> axi_bvalid)
    else begin
      $display("ERROR axi_bvalid dropped before bready, now %h", axi_bvalid);
      errors++;
    end

  `include "axil_bfm_tasks.svh"

  // All control outputs against the model
  task automatic check_controls();
    @(negedge axi_aclk);
    for (int k = 0; k < 12; k++) begin
      check_value(ctrl_name[k], model[k], ctrl_out[k]);
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    if (errors == mark) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s, %0d errors", name, errors - mark);
    end
  endtask

  //**********************************************************************
  // Stimulus
  //**********************************************************************
  initial begin
    cdm_regs_pkg::reg_word_t got;
    int                      mark;
    seed        = 32'h7a35;
    axi_aresetn = 1'b0;
    axi_awaddr  = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_araddr  = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    foreach (status_in[k]) status_in[k] = $random(seed);

    // Reset, then the two quiet edges after release
    mark = errors;
    for (int c = 0; c < 6; c++) begin
      if (c == 4) begin
        @(posedge axi_aclk);
        axi_aresetn <= 1'b1;  // Fifth edge is the last one sampled low
      end
      @(negedge axi_aclk);
      check_value("axi_awready/arready/rvalid/bvalid", '0,
                  32'({axi_awready, axi_arready, axi_rvalid, axi_bvalid}));
    end
    check_controls();
    finish_test("reset state", mark);

    mark = errors;
    for (int k = 0; k < 12; k++) begin
      model[k] = $random(seed);
      axil_write({rw_idx[k], 2'b00}, model[k], 0);
      check_controls();
      axil_read({rw_idx[k], 2'b00}, 0, got);
      check_value("axi_rdata", model[k], got);
    end
    finish_test("write and readback", mark);

    mark = errors;
    for (int k = 0; k < 8; k++) begin
      axil_read({st_idx[k], 2'b00}, 0, got);
      check_value("axi_rdata", status_in[k], got);
    end
    finish_test("status words", mark);

    // Marker on reads, dropped writes leave the model as is
    mark = errors;
    foreach (holes[k]) begin
      axil_read({holes[k], 2'b00}, 0, got);
      check_value("axi_rdata", cdm_regs_pkg::unmapped_read_word, got);
      axil_write({holes[k], 2'b00}, $random(seed), 0);
    end
    foreach (st_idx[k]) axil_write({st_idx[k], 2'b00}, $random(seed), 0);
    check_controls();
    finish_test("unmapped and read-only", mark);

    // AW and AR on one edge, the read goes first
    mark = errors;
    model[1] = $random(seed);
    fork
      axil_write({rw_idx[1], 2'b00}, model[1], 0);
      axil_read({st_idx[0], 2'b00}, 0, got);
    join
    check_value("axi_rdata", status_in[0], got);
    assert (aw_beat_time > r_beat_time) else begin
      $display("Write address was accepted before the read had finished");
      errors++;
    end
    check_controls();
    axil_read({rw_idx[1], 2'b00}, 6, got);        // rready low for 6 clocks
    check_value("axi_rdata", model[1], got);
    model[2] = $random(seed);
    axil_write({rw_idx[2], 2'b00}, model[2], 6);  // bready low for 6 clocks
    check_controls();
    axil_read({rw_idx[2], 2'b00}, 0, got);
    check_value("axi_rdata", model[2], got);
    finish_test("ordering and back-pressure", mark);

    mark = errors;
    for (int off = 1; off < 4; off++) begin
      model[off + 3] = $random(seed);
      axil_write({rw_idx[off + 3], 2'(off)}, model[off + 3], 0);
      check_controls();
      axil_read({rw_idx[off + 3], 2'(3 - off)}, 0, got);
      check_value("axi_rdata", model[off + 3], got);
      axil_read({st_idx[off], 2'(off)}, 0, got);
      check_value("axi_rdata", status_in[off], got);
    end
    finish_test("byte offsets", mark);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_cdm_adapt_ctrl_regs

`default_nettype wire

// ==== cdm_adapt_ctrl.f ====
+incdir+test
verilog/cdm_regs_pkg.sv
verilog/reg_access_if.sv
verilog/axil_slave_port.sv
verilog/cdm_ctrl_reg_bank.sv
verilog/cdm_adapt_ctrl_regs.sv
test/tb_cdm_adapt_ctrl_regs.sv

// ==== Makefile ====
TOP := tb_cdm_adapt_ctrl_regs

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f cdm_adapt_ctrl.f --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
